//--- Bender.yml
package:
  name: cam_display

sources:
  - files:
      - verilog/cam_pkg.sv
      - verilog/video_pkg.sv
      - verilog/fb_wr_if.sv
      - verilog/vid_timing_if.sv
      - verilog/cam_capture.sv
      - verilog/frame_buffer.sv
      - verilog/video_timing.sv
      - verilog/video_out.sv
      - verilog/cam_display_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_cam_display.sv

//--- sim/tb_cam_display.sv
`timescale 1ns/1ps
`default_nettype none

// Camera to display testbench
// Sends one random frame, then checks the next displayed frame against a model
module tb_cam_display;
  import cam_pkg::*;
  import video_pkg::*;

  localparam logic [31:0] SEED = 32'h3e13_111e;
  localparam time DRIVE_DLY  = 2ns;    // Input skew after the rising edge
  localparam int  VS_PERIODS = 400;    // PCLK periods with vsync high
  localparam int  CAM_LINES  = 122;    // Two rows past FB_H
  localparam int  CAM_PIXELS = 168;    // Eight columns past FB_W
  localparam int  FRAME_CLKS = H_TOTAL * V_TOTAL;

  logic      clk;
  logic      rst_n;
  logic      cam_pclk;
  logic      cam_vsync;
  logic      cam_href;
  cam_byte_t cam_data;
  logic      frame_done;
  logic      hsync;
  logic      vsync;
  logic      de;
  colour_t   red;
  colour_t   green;
  colour_t   blue;

  logic [31:0] rng_state;
  rgb565_t     model_mem [FB_H][FB_W];  // Expected buffer contents
  int          check_count;
  int          error_count;
  int          timeout_count;
  int          fd_count;                // frame_done pulses seen so far
  bit          raster_en;

  // Raster monitor state
  int   line_clks;       // Clocks since the last hsync fall
  int   hs_low_clks;
  int   vs_low_clks;
  int   de_high_clks;
  int   since_de_fall;
  int   lines_in_frame;  // hsync falls since the last vsync fall
  int   active_lines;
  int   frames_measured;
  bit   seen_hfall;
  bit   seen_vfall;
  bit   after_de_fall;
  logic prev_hs;
  logic prev_vs;
  logic prev_de;

  tb_clock_gen i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  cam_display_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .cam_pclk   (cam_pclk),
    .cam_vsync  (cam_vsync),
    .cam_href   (cam_href),
    .cam_data   (cam_data),
    .frame_done (frame_done),
    .hsync      (hsync),
    .vsync      (vsync),
    .de         (de),
    .red        (red),
    .green      (green),
    .blue       (blue)
  );

  // 32-bit xorshift, steps the shared state
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic int half_period();
    return 2 + int'(next_random() % 3);  // 2..4 clocks
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_count++;
    $display("Timeout, %s", what);
  endtask

  // One PCLK period, byte and href change with the falling edge
  task automatic send_period(input logic href, input cam_byte_t data);
    cam_pclk = 1'b0;
    cam_href = href;
    cam_data = data;
    repeat (half_period()) @(posedge clk);
    #DRIVE_DLY cam_pclk = 1'b1;
    repeat (half_period()) @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic check_outputs_idle(input string name);
    check_value({name, " de"}, 0, de);
    check_value({name, " frame_done"}, 0, frame_done);
    check_value({name, " hsync"}, 1, hsync);
    check_value({name, " vsync"}, 1, vsync);
    check_value({name, " rgb"}, 0, {red, green, blue});
  endtask

  task automatic check_reset();
    int n;
    n = 0;
    @(negedge clk);
    while (!rst_n && n < 64) begin
      check_outputs_idle("reset");
      @(negedge clk);
      n++;
    end
    if (!rst_n) begin
      report_timeout("rst_n never went high");
    end else begin
      @(negedge clk);  // After the first edge that sees rst_n high
      check_outputs_idle("first clock after reset");
    end
  endtask

  task automatic send_frame();
    rgb565_t pix;
    int      fd_base;
    int      line;
    int      px;
    int      n;
    @(posedge clk);
    #DRIVE_DLY cam_vsync = 1'b1;  // Frame start
    repeat (VS_PERIODS) send_period(1'b0, cam_byte_t'(next_random()));
    cam_vsync = 1'b0;
    repeat (20) send_period(1'b0, cam_byte_t'(next_random()));
    fd_base = fd_count;
    for (line = 0; line < CAM_LINES; line++) begin
      for (px = 0; px < CAM_PIXELS; px++) begin
        pix = rgb565_t'(next_random());
        if (line < FB_H && px < FB_W) model_mem[line][px] = pix;  // Rest is dropped
        send_period(1'b1, pix[15:8]);
        send_period(1'b1, pix[7:0]);
      end
      n = 1 + int'(next_random() % 6);  // Idle gap, href low
      repeat (n) send_period(1'b0, cam_byte_t'(next_random()));
    end
    check_value("frame_done during lines", 0, fd_count - fd_base);
    cam_vsync = 1'b1;  // Frame end
    n = 0;
    while (fd_count == fd_base && n < 32) begin
      @(posedge clk);
      #DRIVE_DLY n++;
    end
    if (fd_count == fd_base) report_timeout("no frame_done pulse after vsync rose");
    repeat (50) send_period(1'b0, cam_byte_t'(next_random()));
    check_value("frame_done pulses after vsync rise", 1, fd_count - fd_base);
  endtask

  task automatic check_pixel(input int x, input int y);
    rgb565_t pix;
    if (x >= H_ACTIVE || y >= V_ACTIVE) begin
      error_count++;
      $display("de was high outside the visible area at x=%0d y=%0d", x, y);
    end else begin
      pix = model_mem[y / 4][x / 4];  // 4x4 block repeat
      check_value($sformatf("red x=%0d y=%0d", x, y), {pix[15:11], 3'b000}, red);
      check_value($sformatf("green x=%0d y=%0d", x, y), {pix[10:5], 2'b00}, green);
      check_value($sformatf("blue x=%0d y=%0d", x, y), {pix[4:0], 3'b000}, blue);
    end
  endtask

  task automatic check_display();
    int   n;
    int   x;
    int   y;
    bit   found;
    logic last_vs;
    logic last_de;
    logic last_hs;
    n       = 0;
    found   = 1'b0;
    last_vs = vsync;
    while (!found && n < 2 * FRAME_CLKS) begin  // Start of the next raster frame
      @(negedge clk);
      found   = last_vs && !vsync;
      last_vs = vsync;
      n++;
    end
    if (!found) begin
      report_timeout("vsync did not fall after frame_done");
      return;
    end
    check_value("blanking rgb", 0, {red, green, blue});
    x       = 0;
    y       = 0;
    n       = 0;
    found   = 1'b0;
    last_de = de;
    last_hs = hsync;
    while (!found && n < FRAME_CLKS + H_TOTAL) begin
      @(negedge clk);
      n++;
      if (last_vs && !vsync) begin
        found = 1'b1;  // Next frame begins
      end else if (de) begin
        check_pixel(x, y);
        x++;
      end else begin
        check_value("blanking rgb", 0, {red, green, blue});
        if (last_de) y++;               // Line done
        if (last_hs && !hsync) x = 0;   // New line
      end
      last_vs = vsync;
      last_de = de;
      last_hs = hsync;
    end
    if (!found) report_timeout("vsync did not fall at the end of the checked frame");
    else check_value("display lines checked", V_ACTIVE, y);
  endtask

  // Raster timing measured on the outputs
  always @(negedge clk) begin
    if (raster_en) begin
      line_clks++;
      since_de_fall++;
      if (!de && prev_de) begin
        check_value("de high clocks per line", H_ACTIVE, de_high_clks);
        de_high_clks  = 0;
        since_de_fall = 0;
        after_de_fall = 1'b1;
        active_lines++;
      end
      if (de) de_high_clks++;
      if (!hsync && prev_hs) begin
        if (seen_hfall) check_value("line length", H_TOTAL, line_clks);
        if (after_de_fall) check_value("de fall to hsync fall", H_FRONT, since_de_fall);
        seen_hfall    = 1'b1;
        after_de_fall = 1'b0;
        line_clks     = 0;
        lines_in_frame++;
      end
      if (!hsync) hs_low_clks++;
      if (hsync && !prev_hs) begin
        check_value("hsync low clocks", H_SYNC, hs_low_clks);
        hs_low_clks = 0;
      end
      if (!vsync && prev_vs) begin
        if (seen_vfall) begin
          check_value("lines per frame", V_TOTAL, lines_in_frame);
          check_value("active lines per frame", V_ACTIVE, active_lines);
          frames_measured++;
        end
        seen_vfall     = 1'b1;
        lines_in_frame = 0;
        active_lines   = 0;
      end
      if (!vsync) vs_low_clks++;
      if (vsync && !prev_vs) begin
        check_value("vsync low clocks", V_SYNC * H_TOTAL, vs_low_clks);
        vs_low_clks = 0;
      end
    end
    prev_hs = hsync;
    prev_vs = vsync;
    prev_de = de;
  end

  always @(negedge clk) begin
    if (frame_done === 1'b1) fd_count++;
  end

  initial begin
    rng_state = SEED;
    cam_pclk  = 1'b0;
    cam_vsync = 1'b0;
    cam_href  = 1'b0;
    cam_data  = '0;
    check_reset();
    raster_en = 1'b1;
    if (timeout_count == 0) send_frame();
    if (timeout_count == 0) check_display();
    @(posedge clk);  // Let the raster monitor finish the last falling edge
    check_value("raster frames measured", 1, frames_measured > 0);
    $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench clock and reset
// 25 MHz clock, reset held low for the first 16 rising edges
module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 rst_n = 1'b1;  // Released off the edge, like the other inputs
  end

endmodule

`default_nettype wire

//--- verilog.f
verilog/cam_pkg.sv
verilog/video_pkg.sv
verilog/fb_wr_if.sv
verilog/vid_timing_if.sv
verilog/cam_capture.sv
verilog/frame_buffer.sv
verilog/video_timing.sv
verilog/video_out.sv
verilog/cam_display_top.sv
sim/tb_clock_gen.sv
sim/tb_cam_display.sv

//--- verilog/cam_capture.sv
`timescale 1ns/1ps
`default_nettype none

// Camera port capture
// PCLK is sampled as data in the clk domain, so it must stay at or below clk/4
module cam_capture (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cam_pclk,
  input  logic               cam_vsync,
  input  logic               cam_href,
  input  cam_pkg::cam_byte_t cam_data,
  fb_wr_if.src               wr
);
  import cam_pkg::*;
  import video_pkg::*;

  typedef enum logic [1:0] {
    WAIT_FRAME,  // Out of reset, no frame start seen yet
    HIGH_BYTE,   // Next byte is [15:8]
    LOW_BYTE     // Next byte is [7:0]
  } cap_state_t;

  logic [1:0] pclk_sync;   // Two stage synchronizers
  logic [1:0] vsync_sync;
  logic [1:0] href_sync;
  cam_byte_t  data_meta;
  cam_byte_t  data_sync;
  logic       pclk_prev;   // Edge detect history
  logic       vsync_prev;
  logic       href_prev;
  logic       pclk_rise;
  logic       href_fall;
  logic       vsync_rise;
  logic       pix_edge;    // Byte strobe inside a line
  logic       hi_take;
  logic       lo_take;
  logic       in_range;    // Pixel lands inside the stored frame
  cap_state_t state;
  cam_byte_t  hi_byte;
  fb_x_t      col;
  fb_y_t      row;

  // Control level synchronizers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pclk_sync  <= '0;
      vsync_sync <= '0;
      href_sync  <= '0;
      pclk_prev  <= 1'b0;
      vsync_prev <= 1'b0;
      href_prev  <= 1'b0;
    end else begin
      pclk_sync  <= {pclk_sync[0], cam_pclk};
      vsync_sync <= {vsync_sync[0], cam_vsync};
      href_sync  <= {href_sync[0], cam_href};
      pclk_prev  <= pclk_sync[1];
      vsync_prev <= vsync_sync[1];
      href_prev  <= href_sync[1];
    end
  end

  // Data bus, same two stages as PCLK so a byte lines up with its edge
  always_ff @(posedge clk) begin
    data_meta <= cam_data;
    data_sync <= data_meta;
  end

  assign pclk_rise  = pclk_sync[1] & ~pclk_prev;
  assign href_fall  = ~href_sync[1] & href_prev;
  assign vsync_rise = vsync_sync[1] & ~vsync_prev;

  // Line end and frame reset take priority over a byte
  assign pix_edge = pclk_rise & href_sync[1] & ~vsync_sync[1];
  assign hi_take  = pix_edge && (state == HIGH_BYTE);
  assign lo_take  = pix_edge && (state == LOW_BYTE);
  assign in_range = (int'(col) < FB_W) && (int'(row) < FB_H);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state         <= WAIT_FRAME;
      col           <= '0;
      row           <= '0;
      wr.we         <= 1'b0;
      wr.frame_done <= 1'b0;
    end else begin
      wr.we         <= 1'b0;
      wr.frame_done <= vsync_rise;  // Frame closes when VSYNC goes high
      if (vsync_sync[1]) begin
        col   <= '0;
        row   <= '0;
        state <= HIGH_BYTE;
      end else if (href_fall && state != WAIT_FRAME) begin
        col   <= '0;
        row   <= (row == '1) ? row : row + 1'b1;  // Hold at top, never wraps
        state <= HIGH_BYTE;                       // Drop a lone high byte
      end else if (hi_take) begin
        state <= LOW_BYTE;
      end else if (lo_take) begin
        state <= HIGH_BYTE;
        col   <= (col == '1) ? col : col + 1'b1;
        wr.we <= in_range;  // Out of range pixels just advance the column
      end
    end
  end

  // Pixel assembly and address
  always_ff @(posedge clk) begin
    if (hi_take) hi_byte <= data_sync;
    if (lo_take) begin
      wr.wdata <= {hi_byte, data_sync};
      wr.waddr <= fb_addr_t'(int'(row) * FB_W + int'(col));
    end
  end

endmodule

`default_nettype wire

//--- verilog/cam_display_top.sv
`timescale 1ns/1ps
`default_nettype none

// Camera to display top level
// Capture writes the buffer, the raster reads it back 4x upscaled
module cam_display_top (
  input  logic               clk,        // 25 MHz pixel clock
  input  logic               rst_n,
  input  logic               cam_pclk,   // Sampled, not used as a clock
  input  logic               cam_vsync,
  input  logic               cam_href,
  input  cam_pkg::cam_byte_t cam_data,
  output logic               frame_done,
  output logic               hsync,
  output logic               vsync,
  output logic               de,
  output video_pkg::colour_t red,
  output video_pkg::colour_t green,
  output video_pkg::colour_t blue
);

  fb_wr_if      wr_bus ();
  vid_timing_if tim_bus ();

  video_pkg::fb_addr_t raddr;  // Display read address
  cam_pkg::rgb565_t    rdata;  // Read data, one clock after raddr

  assign frame_done = wr_bus.frame_done;

  cam_capture i_capture (
    .clk       (clk),
    .rst_n     (rst_n),
    .cam_pclk  (cam_pclk),
    .cam_vsync (cam_vsync),
    .cam_href  (cam_href),
    .cam_data  (cam_data),
    .wr        (wr_bus.src)
  );

  frame_buffer i_frame_buffer (
    .clk   (clk),
    .wr    (wr_bus.dst),
    .raddr (raddr),
    .rdata (rdata)
  );

  video_timing i_timing (
    .clk   (clk),
    .rst_n (rst_n),
    .tim   (tim_bus.src)
  );

  video_out i_video_out (
    .clk   (clk),
    .rst_n (rst_n),
    .tim   (tim_bus.dst),
    .raddr (raddr),
    .rdata (rdata),
    .hsync (hsync),
    .vsync (vsync),
    .de    (de),
    .red   (red),
    .green (green),
    .blue  (blue)
  );

endmodule

`default_nettype wire

//--- verilog/cam_pkg.sv
`default_nettype none

// Camera side definitions
// The sensor sends RGB565 as two bytes per pixel, high byte first
package cam_pkg;

  // Stored frame size in pixels
  localparam int FB_W = 160;  // Columns kept from each line
  localparam int FB_H = 120;  // Rows kept from each frame

  // Parallel data bus from the sensor
  typedef logic [7:0] cam_byte_t;

  // Packed pixel
  // [15:11] red, [10:5] green, [4:0] blue
  typedef logic [15:0] rgb565_t;

  // Position inside the stored frame
  typedef logic [7:0] fb_x_t;  // 0..255, covers FB_W and the dropped tail
  typedef logic [6:0] fb_y_t;  // 0..127, covers FB_H and the dropped tail

endpackage

`default_nettype wire

//--- verilog/fb_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

// Write side of the frame buffer plus end of frame marker
interface fb_wr_if;
  import cam_pkg::*;
  import video_pkg::*;

  logic     we;          // One cycle write strobe
  fb_addr_t waddr;       // Word address, row * FB_W + column
  rgb565_t  wdata;       // Pixel to store
  logic     frame_done;  // One cycle pulse at end of frame

  // Capture side
  modport src (
    output we, waddr, wdata, frame_done
  );

  // RAM side, no use for frame_done
  modport dst (
    input we, waddr, wdata
  );

endinterface

`default_nettype wire

//--- verilog/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// Frame store, one write port from capture, one read port for display
// Both ports run on clk, writes never stall
module frame_buffer (
  input  logic               clk,
  fb_wr_if.dst               wr,
  input  video_pkg::fb_addr_t raddr,
  output cam_pkg::rgb565_t   rdata
);
  import cam_pkg::*;
  import video_pkg::*;

  // Maps to block RAM
  // Contents start undefined until the first frame lands
  rgb565_t mem [FB_DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr.waddr] <= wr.wdata;
    end
  end

  // Read port, data valid one clock after raddr
  // Read during write to the same word returns the old pixel
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

//--- verilog/vid_timing_if.sv
`timescale 1ns/1ps
`default_nettype none

// Raster position and sync levels
interface vid_timing_if;
  import video_pkg::*;

  hcount_t hcount;  // 0..H_TOTAL-1
  vcount_t vcount;  // 0..V_TOTAL-1
  logic    active;  // Visible area
  logic    hsync;   // Active low
  logic    vsync;   // Active low

  // Timing generator side
  modport src (
    output hcount, vcount, active, hsync, vsync
  );

  // Pixel output side
  modport dst (
    input hcount, vcount, active, hsync, vsync
  );

endinterface

`default_nettype wire

//--- verilog/video_out.sv
`timescale 1ns/1ps
`default_nettype none

// Pixel output stage
// Each stored pixel covers a 4x4 block of the raster
module video_out (
  input  logic                clk,
  input  logic                rst_n,
  vid_timing_if.dst           tim,
  output video_pkg::fb_addr_t raddr,
  input  cam_pkg::rgb565_t    rdata,
  output logic                hsync,
  output logic                vsync,
  output logic                de,
  output video_pkg::colour_t  red,
  output video_pkg::colour_t  green,
  output video_pkg::colour_t  blue
);
  import cam_pkg::*;
  import video_pkg::*;

  fb_x_t col;
  fb_y_t row;

  // Divide by 4
  assign col = tim.hcount[9:2];  // 0..159 while active
  assign row = tim.vcount[8:2];  // 0..119 while active

  // Park on word 0 outside the visible area, keeps reads in range
  always_comb begin
    if (tim.active) raddr = fb_addr_t'(int'(row) * FB_W + int'(col));
    else            raddr = '0;
  end

  // One clock delay, matches the RAM read latency
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      de    <= 1'b0;
      hsync <= 1'b1;
      vsync <= 1'b1;
    end else begin
      de    <= tim.active;
      hsync <= tim.hsync;
      vsync <= tim.vsync;
    end
  end

  // 565 to 888, low bits zero filled
  // Black outside the visible area
  assign red   = de ? {rdata[15:11], 3'b000} : '0;
  assign green = de ? {rdata[10:5], 2'b00}   : '0;
  assign blue  = de ? {rdata[4:0], 3'b000}   : '0;

endmodule

`default_nettype wire

//--- verilog/video_pkg.sv
`default_nettype none

// Display side definitions
// Standard 640x480 at 60 Hz, 25 MHz pixel rate
package video_pkg;

  // Horizontal timing in clocks
  localparam int H_ACTIVE = 640;
  localparam int H_FRONT  = 16;
  localparam int H_SYNC   = 96;
  localparam int H_BACK   = 48;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 800

  // Vertical timing in lines
  localparam int V_ACTIVE = 480;
  localparam int V_FRONT  = 10;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 33;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 525

  // Sync pulse windows, end exclusive
  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;      // 656
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;   // 752
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;      // 490
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;   // 492

  // Raster position
  typedef logic [9:0] hcount_t;
  typedef logic [9:0] vcount_t;

  // Frame buffer geometry, row * FB_W + column
  localparam int FB_DEPTH = cam_pkg::FB_W * cam_pkg::FB_H;  // 19200 words
  typedef logic [14:0] fb_addr_t;

  // One output colour channel
  typedef logic [7:0] colour_t;

endpackage

`default_nettype wire

//--- verilog/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

// 640x480 raster generator
// Counters free run from reset, position and levels leave through registers
module video_timing (
  input  logic     clk,
  input  logic     rst_n,
  vid_timing_if.src tim
);
  import video_pkg::*;

  hcount_t h_cnt;
  vcount_t v_cnt;
  logic    h_end;    // Last clock of a line
  logic    v_end;    // Last line of a frame
  logic    act_d;    // Decoded levels for the current count
  logic    hsync_d;
  logic    vsync_d;

  assign h_end = (h_cnt == hcount_t'(H_TOTAL - 1));
  assign v_end = (v_cnt == vcount_t'(V_TOTAL - 1));

  // Horizontal wraps every line, vertical steps on the wrap
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_end) begin
      h_cnt <= '0;
      v_cnt <= v_end ? '0 : v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // Level decode
  always_comb begin
    act_d   = (int'(h_cnt) < H_ACTIVE) && (int'(v_cnt) < V_ACTIVE);
    hsync_d = !((int'(h_cnt) >= H_SYNC_START) && (int'(h_cnt) < H_SYNC_END));
    vsync_d = !((int'(v_cnt) >= V_SYNC_START) && (int'(v_cnt) < V_SYNC_END));
  end

  // Counts and levels registered together, so they stay aligned
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tim.hcount <= '0;
      tim.vcount <= '0;
      tim.active <= 1'b0;
      tim.hsync  <= 1'b1;  // Idle high
      tim.vsync  <= 1'b1;
    end else begin
      tim.hcount <= h_cnt;
      tim.vcount <= v_cnt;
      tim.active <= act_d;
      tim.hsync  <= hsync_d;
      tim.vsync  <= vsync_d;
    end
  end

endmodule

`default_nettype wire
